//--- design/mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// Datapath sizes
`define MIPS_XLEN      32
`define MIPS_RBITS     5
`define MIPS_NREGS     32
`define MIPS_IMM_BITS  16
`define MIPS_PC_STEP   4

// --------------------
// Instruction fields
`define MIPS_OP_HI     31
`define MIPS_OP_LO     26
`define MIPS_RS_HI     25
`define MIPS_RS_LO     21
`define MIPS_RT_HI     20
`define MIPS_RT_LO     16
`define MIPS_RD_HI     15
`define MIPS_RD_LO     11
`define MIPS_FUNCT_HI  5
`define MIPS_FUNCT_LO  0

`endif

//--- design/mips_pkg.sv
`default_nettype none

`include "mips_defines.svh"

package mips_pkg;

	typedef logic [`MIPS_XLEN-1:0]  word_t;
	typedef logic [`MIPS_RBITS-1:0] reg_addr_t;

	typedef enum logic [5:0] {
		OP_RTYPE = 6'b000000,
		OP_ADDI  = 6'b001000,
		OP_ADDIU = 6'b001001,
		OP_SLTI  = 6'b001010,
		OP_SLTIU = 6'b001011,
		OP_ORI   = 6'b001101,
		OP_LUI   = 6'b001111
	} opcode_t;

	typedef enum logic [5:0] {
		FN_ADD  = 6'b100000,
		FN_ADDU = 6'b100001,
		FN_SUB  = 6'b100010,
		FN_SUBU = 6'b100011,
		FN_AND  = 6'b100100,
		FN_OR   = 6'b100101,
		FN_SLT  = 6'b101010,
		FN_SLTU = 6'b101011
	} funct_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT,
		ALU_SLTU
	} alu_op_t;

	typedef enum logic [1:0] {
		FWD_RF,
		FWD_MEM,
		FWD_WB
	} fwd_sel_t;

	// --------------------
	// Stage payloads
	typedef struct packed {
		logic  valid;
		word_t instr;
	} if_id_t;

	typedef struct packed {
		logic      regwrite;
		reg_addr_t dest;
		reg_addr_t rs;
		reg_addr_t rt;
		word_t     rs_val;
		word_t     rt_val;
		word_t     imm;      // Already sign or zero extended
		logic      alusrc;
		logic      shiftl16;
		alu_op_t   alu_op;
	} id_ex_t;

	typedef struct packed {
		logic      regwrite;
		reg_addr_t dest;
		word_t     result;
	} ex_mem_t;

	typedef struct packed {
		logic      valid;
		reg_addr_t dest;
		word_t     data;
	} wb_t;

endpackage

`default_nettype wire

//--- design/pipe_reg.sv
`timescale 1ns/1ns
`default_nettype none

module pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     reset,
	input  payload_t d,
	output payload_t q
);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			q <= '0;   // Clears every valid/regwrite bit
		end else begin
			q <= d;
		end
	end

endmodule

`default_nettype wire

//--- design/regfile.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_defines.svh"

module regfile import mips_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  reg_addr_t ra1,
	input  reg_addr_t ra2,
	input  wb_t       wr,
	output word_t     rd1,
	output word_t     rd2
);

	word_t regs [1:`MIPS_NREGS-1];   // No storage for r0

	function automatic word_t read_port(input reg_addr_t addr);
		if (addr == '0)
			return '0;
		if (wr.valid && wr.dest == addr)
			return wr.data;   // Same-cycle write bypass
		return regs[addr];
	endfunction

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 1; i < `MIPS_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.valid) begin
			regs[wr.dest] <= wr.data;
		end
	end

	assign rd1 = read_port(ra1);
	assign rd2 = read_port(ra2);

endmodule

`default_nettype wire

//--- design/decoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_defines.svh"

module decoder import mips_pkg::*; (
	input  if_id_t fetched,
	input  word_t  rd1,
	input  word_t  rd2,
	output id_ex_t ctrl
);

	opcode_t                   op;
	funct_t                    fn;
	logic [`MIPS_IMM_BITS-1:0] imm16;
	reg_addr_t                 rs;
	reg_addr_t                 rt;
	reg_addr_t                 rd;
	logic                      known;
	logic                      signext;
	logic                      use_rd;

	assign op    = opcode_t'(fetched.instr[`MIPS_OP_HI:`MIPS_OP_LO]);
	assign fn    = funct_t'(fetched.instr[`MIPS_FUNCT_HI:`MIPS_FUNCT_LO]);
	assign imm16 = fetched.instr[`MIPS_IMM_BITS-1:0];
	assign rs    = fetched.instr[`MIPS_RS_HI:`MIPS_RS_LO];
	assign rt    = fetched.instr[`MIPS_RT_HI:`MIPS_RT_LO];
	assign rd    = fetched.instr[`MIPS_RD_HI:`MIPS_RD_LO];

	always_comb begin
		known         = 1'b1;
		signext       = 1'b1;
		use_rd        = 1'b0;
		ctrl.alusrc   = 1'b1;
		ctrl.shiftl16 = 1'b0;
		ctrl.alu_op   = ALU_ADD;
		case (op)
			OP_RTYPE: begin
				use_rd      = 1'b1;
				ctrl.alusrc = 1'b0;
				case (fn)
					FN_ADD, FN_ADDU: ctrl.alu_op = ALU_ADD;   // No overflow trap
					FN_SUB, FN_SUBU: ctrl.alu_op = ALU_SUB;
					FN_AND:          ctrl.alu_op = ALU_AND;
					FN_OR:           ctrl.alu_op = ALU_OR;
					FN_SLT:          ctrl.alu_op = ALU_SLT;
					FN_SLTU:         ctrl.alu_op = ALU_SLTU;
					default:         known = 1'b0;
				endcase
			end
			OP_ADDI, OP_ADDIU: ctrl.alu_op = ALU_ADD;
			OP_SLTI:           ctrl.alu_op = ALU_SLT;
			OP_SLTIU:          ctrl.alu_op = ALU_SLTU;   // Sign-extended, compared unsigned
			OP_ORI: begin
				signext     = 1'b0;
				ctrl.alu_op = ALU_OR;
			end
			OP_LUI: begin
				signext       = 1'b0;
				ctrl.shiftl16 = 1'b1;
			end
			default: known = 1'b0;
		endcase

		ctrl.dest     = use_rd ? rd : rt;
		ctrl.regwrite = fetched.valid && known && (ctrl.dest != '0);

		// LUI ignores rs, so read it as r0
		ctrl.rs     = (op == OP_LUI) ? '0 : rs;
		ctrl.rs_val = (op == OP_LUI) ? '0 : rd1;
		ctrl.rt     = rt;
		ctrl.rt_val = rd2;

		if (signext)
			ctrl.imm = {{(`MIPS_XLEN-`MIPS_IMM_BITS){imm16[`MIPS_IMM_BITS-1]}}, imm16};
		else
			ctrl.imm = {{(`MIPS_XLEN-`MIPS_IMM_BITS){1'b0}}, imm16};
	end

endmodule

`default_nettype wire

//--- design/alu.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_defines.svh"

module alu import mips_pkg::*; (
	input  word_t   a,
	input  word_t   b,
	input  alu_op_t op,
	output word_t   result
);

	logic              sub;
	word_t             b_in;
	logic [`MIPS_XLEN:0] sum_ext;
	word_t             sum;
	logic              carry;
	logic              ovf;
	logic              lt_s;
	logic              lt_u;

	// --------------------
	// Shared add/subtract chain
	assign sub     = (op == ALU_SUB) || (op == ALU_SLT) || (op == ALU_SLTU);
	assign b_in    = sub ? ~b : b;
	assign sum_ext = {1'b0, a} + {1'b0, b_in} + {{`MIPS_XLEN{1'b0}}, sub};
	assign sum     = sum_ext[`MIPS_XLEN-1:0];
	assign carry   = sum_ext[`MIPS_XLEN];

	assign ovf  = (a[`MIPS_XLEN-1] == b_in[`MIPS_XLEN-1]) &&
	              (sum[`MIPS_XLEN-1] != a[`MIPS_XLEN-1]);
	assign lt_s = sum[`MIPS_XLEN-1] ^ ovf;   // N xor V
	assign lt_u = ~carry;                    // Borrow out

	always_comb begin
		case (op)
			ALU_ADD,
			ALU_SUB:  result = sum;
			ALU_AND:  result = a & b;
			ALU_OR:   result = a | b;
			ALU_SLT:  result = {{(`MIPS_XLEN-1){1'b0}}, lt_s};
			ALU_SLTU: result = {{(`MIPS_XLEN-1){1'b0}}, lt_u};
			default:  result = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- design/forwarding_unit.sv
`timescale 1ns/1ns
`default_nettype none

module forwarding_unit import mips_pkg::*; (
	input  reg_addr_t rs,
	input  reg_addr_t rt,
	input  ex_mem_t   mem,
	input  wb_t       wb,
	output fwd_sel_t  sel_a,
	output fwd_sel_t  sel_b
);

	// Younger result in the memory stage wins
	function automatic fwd_sel_t pick(input reg_addr_t src);
		if (mem.regwrite && mem.dest == src)
			return FWD_MEM;
		if (wb.valid && wb.dest == src)
			return FWD_WB;
		return FWD_RF;
	endfunction

	assign sel_a = pick(rs);
	assign sel_b = pick(rt);

endmodule

`default_nettype wire

//--- design/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_defines.svh"

module execute_stage import mips_pkg::*; (
	input  id_ex_t  ex,
	input  ex_mem_t mem,
	input  wb_t     wb,
	output ex_mem_t out
);

	fwd_sel_t sel_a;
	fwd_sel_t sel_b;
	word_t    op_a;
	word_t    op_b;
	word_t    imm_op;
	word_t    alu_b;
	word_t    alu_y;

	function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t rf_val);
		case (sel)
			FWD_MEM: return mem.result;
			FWD_WB:  return wb.data;
			default: return rf_val;
		endcase
	endfunction

	forwarding_unit i_forwarding_unit (
		.rs    (ex.rs),
		.rt    (ex.rt),
		.mem   (mem),
		.wb    (wb),
		.sel_a (sel_a),
		.sel_b (sel_b)
	);

	assign op_a   = fwd_mux(sel_a, ex.rs_val);
	assign op_b   = fwd_mux(sel_b, ex.rt_val);
	assign imm_op = ex.shiftl16 ?
	                {ex.imm[`MIPS_IMM_BITS-1:0], {`MIPS_IMM_BITS{1'b0}}} : ex.imm;   // LUI
	assign alu_b  = ex.alusrc ? imm_op : op_b;

	alu i_alu (
		.a      (op_a),
		.b      (alu_b),
		.op     (ex.alu_op),
		.result (alu_y)
	);

	assign out.regwrite = ex.regwrite;
	assign out.dest     = ex.dest;
	assign out.result   = alu_y;

endmodule

`default_nettype wire

//--- design/mips_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_defines.svh"

module mips_core import mips_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	output word_t pc,
	input  word_t instr,
	output wb_t   wb
);

	if_id_t  if_id_d;
	if_id_t  if_id_q;
	id_ex_t  id_ex_d;
	id_ex_t  id_ex_q;
	ex_mem_t ex_mem_d;
	ex_mem_t ex_mem_q;
	wb_t     mem_wb_d;
	wb_t     mem_wb_q;
	word_t   rd1;
	word_t   rd2;

	// --------------------
	// Fetch
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc <= '0;
		end else begin
			pc <= pc + `MIPS_XLEN'(`MIPS_PC_STEP);
		end
	end

	assign if_id_d.valid = !reset;
	assign if_id_d.instr = instr;   // Same-cycle instruction lookup

	pipe_reg #(.payload_t(if_id_t)) i_if_id (
		.clk   (clk),
		.reset (reset),
		.d     (if_id_d),
		.q     (if_id_q)
	);

	// --------------------
	// Decode
	regfile i_regfile (
		.clk   (clk),
		.reset (reset),
		.ra1   (if_id_q.instr[`MIPS_RS_HI:`MIPS_RS_LO]),
		.ra2   (if_id_q.instr[`MIPS_RT_HI:`MIPS_RT_LO]),
		.wr    (mem_wb_q),
		.rd1   (rd1),
		.rd2   (rd2)
	);

	decoder i_decoder (
		.fetched (if_id_q),
		.rd1     (rd1),
		.rd2     (rd2),
		.ctrl    (id_ex_d)
	);

	pipe_reg #(.payload_t(id_ex_t)) i_id_ex (
		.clk   (clk),
		.reset (reset),
		.d     (id_ex_d),
		.q     (id_ex_q)
	);

	// --------------------
	// Execute
	execute_stage i_execute_stage (
		.ex  (id_ex_q),
		.mem (ex_mem_q),
		.wb  (mem_wb_q),
		.out (ex_mem_d)
	);

	pipe_reg #(.payload_t(ex_mem_t)) i_ex_mem (
		.clk   (clk),
		.reset (reset),
		.d     (ex_mem_d),
		.q     (ex_mem_q)
	);

	// Memory stage only carries the result
	assign mem_wb_d.valid = ex_mem_q.regwrite;
	assign mem_wb_d.dest  = ex_mem_q.dest;
	assign mem_wb_d.data  = ex_mem_q.result;

	pipe_reg #(.payload_t(wb_t)) i_mem_wb (
		.clk   (clk),
		.reset (reset),
		.d     (mem_wb_d),
		.q     (mem_wb_q)
	);

	assign wb = mem_wb_q;

endmodule

`default_nettype wire

//--- dv/mips_sva.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_defines.svh"

module mips_sva import mips_pkg::*; (
	input logic  clk,
	input logic  reset,
	input word_t pc,
	input wb_t   wb
);

	wb_dest_nonzero: assert property (@(posedge clk) disable iff (reset)
		wb.valid |-> wb.dest != '0)
		else $error("Writeback to r0 seen on the wb port");

	// First edge out of reset keeps pc at 0
	pc_steps: assert property (@(posedge clk) disable iff (reset)
		!$past(reset) |-> pc == $past(pc) + `MIPS_XLEN'(`MIPS_PC_STEP))
		else $error("pc did not advance by one word");

	wb_data_known: assert property (@(posedge clk) disable iff (reset)
		wb.valid |-> !$isunknown(wb.data))
		else $error("wb.data has unknown bits while valid");

endmodule

bind mips_core mips_sva i_mips_sva (
	.clk   (clk),
	.reset (reset),
	.pc    (pc),
	.wb    (wb)
);

`default_nettype wire

//--- dv/mips_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mips_tb import mips_pkg::*;;

	localparam int TIMEOUT_CYCLES = 200;
	localparam int DRAIN_CYCLES   = 8;

	logic  clk;
	logic  reset;
	word_t pc;
	word_t instr;
	wb_t   wb;

	word_t prog [$];   // Program words in address order
	wb_t   exp_q [$];  // Expected writebacks in order
	int    errors;
	int    checks;
	int    got;

	mips_core i_mips_core (
		.clk   (clk),
		.reset (reset),
		.pc    (pc),
		.instr (instr),
		.wb    (wb)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// --------------------
	// Instruction memory model
	function automatic word_t fetch_word(input word_t addr);
		int idx;
		idx = int'(addr >> 2);
		if (idx < prog.size())
			return prog[idx];
		return '0;   // NOP past the end
	endfunction

	always @(posedge clk) begin
		#1;
		instr = fetch_word(pc);
	end

	task automatic load_patterns();
		int        fd;
		int        n;
		string     line;
		word_t     w;
		reg_addr_t rn;
		wb_t       e;
		fd = $fopen("dv/mips_patterns.txt", "r");
		if (fd == 0) begin
			$display("Could not open the pattern file dv/mips_patterns.txt");
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n > 0) begin
				if ($sscanf(line, "i %h", w) == 1) begin
					prog.push_back(w);
				end else if ($sscanf(line, "w %h %h", rn, w) == 2) begin
					e.valid = 1'b1;
					e.dest  = rn;
					e.data  = w;
					exp_q.push_back(e);
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic compare_writeback();
		if (got < exp_q.size()) begin
			checks++;
			if (wb.dest !== exp_q[got].dest) begin
				$display("ERROR wb.dest: got 0x%h expected 0x%h (writeback %0d)",
				         wb.dest, exp_q[got].dest, got);
				errors++;
			end
			if (wb.data !== exp_q[got].data) begin
				$display("ERROR wb.data: got 0x%h expected 0x%h (writeback %0d)",
				         wb.data, exp_q[got].data, got);
				errors++;
			end
		end else begin
			$display("Unexpected extra writeback to r%0d with data 0x%h", wb.dest, wb.data);
			errors++;
		end
		got++;
	endtask

	// --------------------
	initial begin
		int cycles;
		errors = 0;
		checks = 0;
		got    = 0;
		reset  = 1'b1;
		instr  = '0;
		load_patterns();
		if (exp_q.size() == 0 && errors == 0) begin
			$display("The pattern file holds no expected writebacks");
			errors++;
		end

		repeat (8) begin
			@(posedge clk);
			#1;
			checks++;
			if (pc !== 32'h0) begin
				$display("ERROR pc: got 0x%h expected 0x%h during reset", pc, 32'h0);
				errors++;
			end
			if (wb.valid !== 1'b0) begin
				$display("ERROR wb.valid: got 0x%h expected 0x%h during reset", wb.valid, 1'b0);
				errors++;
			end
		end
		reset = 1'b0;

		// Pipeline still filling
		for (int i = 0; i < 4; i++) begin
			@(negedge clk);
			checks++;
			if (i == 0 && pc !== 32'h0) begin
				$display("ERROR pc: got 0x%h expected 0x%h after reset", pc, 32'h0);
				errors++;
			end
			if (wb.valid !== 1'b0) begin
				$display("ERROR wb.valid: got 0x%h expected 0x%h in cycle %0d after reset",
				         wb.valid, 1'b0, i);
				errors++;
			end
		end

		cycles = 0;
		while (got < exp_q.size() && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			cycles++;
			if (cycles == 1) begin   // First program word is due here
				checks++;
				if (wb.valid !== 1'b1) begin
					$display("ERROR wb.valid: got 0x%h expected 0x%h in cycle 4 after reset",
					         wb.valid, 1'b1);
					errors++;
				end
			end
			if (wb.valid)
				compare_writeback();
		end
		if (got < exp_q.size()) begin
			$display("Timed out after %0d cycles with %0d of %0d writebacks seen",
			         cycles, got, exp_q.size());
			errors++;
		end

		repeat (DRAIN_CYCLES) begin
			@(negedge clk);
			if (wb.valid)
				compare_writeback();
		end
		checks++;
		if (got != exp_q.size()) begin
			$display("ERROR writeback_count: got 0x%h expected 0x%h", got, exp_q.size());
			errors++;
		end

		$display("Done: %0d checks, %0d errors, %0d writebacks", checks, errors, got);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/mips_patterns.txt
# i <instruction word>             program in address order from pc 0
# w <dest register> <data>         expected writebacks in order, all hex
i 2001FFFB   # addi  r1, r0, -5
i 34028001   # ori   r2, r0, 0x8001
i 3C038000   # lui   r3, 0x8000
i 2824FFFF   # slti  r4, r1, -1
i 2C25FFFF   # sltiu r5, r1, -1
i 2C460001   # sltiu r6, r2, 1
i 0062382A   # slt   r7, r3, r2
i 0062402B   # sltu  r8, r3, r2
i 00224820   # add   r9, r1, r2
i 01215022   # sub   r10, r9, r1
i 01495825   # or    r11, r10, r9
i 01616024   # and   r12, r11, r1
i 240D0011   # addiu r13, r0, 0x11
i 25AD0100   # addiu r13, r13, 0x100
i 01AD7021   # addu  r14, r13, r13
i 000E7823   # subu  r15, r0, r14
i 20200007   # addi  r0, r1, 7
i 8C100004   # lw, not decoded
i 00228826   # xor, not decoded
i 000E9020   # add   r18, r0, r14
i 00009825   # or    r19, r0, r0
w 01 FFFFFFFB
w 02 00008001
w 03 80000000
w 04 00000001
w 05 00000001
w 06 00000000
w 07 00000001
w 08 00000000
w 09 00007FFC
w 0A 00008001
w 0B 0000FFFD
w 0C 0000FFF9
w 0D 00000011
w 0D 00000111
w 0E 00000222
w 0F FFFFFDDE
w 12 00000222
w 13 00000000

//--- files.f
+incdir+design
design/mips_pkg.sv
design/pipe_reg.sv
design/regfile.sv
design/decoder.sv
design/alu.sv
design/forwarding_unit.sv
design/execute_stage.sv
design/mips_core.sv
dv/mips_sva.sv
dv/mips_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module mips_tb -o mips_sim
out=$(./obj_dir/mips_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'PASS: all tests'; then
	exit 0
fi
exit 1
